// File: design/sensor_regs_pkg.sv
//====================
// command port register map for one sensor channel
// offsets are relative to the channel base address parameter
// also holds the two decodings of the gamma address/data word
//====================
`default_nettype none

package sensor_regs_pkg;

    localparam int CMD_NUM_BYTES = 6; // AL, AH, D0..D3

    // register offsets from base
    localparam int SENSOR_CTRL_RADDR          = 0; // mode register
    localparam int SENS_GAMMA_CTRL_RADDR      = 4; // gamma control
    localparam int SENS_GAMMA_ADDR_DATA_RADDR = 5; // gamma table address or data

    // bit positions
    localparam int SENSOR_16BIT_BIT    = 8;  // 1 - raw 16 bpp, 0 - packed 8 bpp
    localparam int SENS_GAMMA_MODE_EN  = 3;  // table lookup enable
    localparam int GAMMA_ADDR_FLAG_BIT = 20; // set - word carries table address

    typedef logic [31:0] cmd_data_t; // four data bytes, D0 in low byte
    typedef logic [15:0] cmd_addr_t; // two address bytes, AL in low byte

    // address view, flag set
    typedef struct packed {
        logic [31:GAMMA_ADDR_FLAG_BIT+1] rsvd_hi;   // ignored
        logic                            addr_flag; // selects this view
        logic [GAMMA_ADDR_FLAG_BIT-1:8]  rsvd_lo;   // ignored
        logic [7:0]                      tbl_addr;  // new table pointer
    } gamma_addr_view_t;

    // data view, flag clear
    typedef struct packed {
        logic [31:8] rsvd;  // flag lives in here, zero
        logic [7:0]  value; // entry written at current pointer
    } gamma_data_view_t;

    typedef union packed {
        gamma_addr_view_t addr;
        gamma_data_view_t data;
    } gamma_word_t;

endpackage

`default_nettype wire

// File: design/pixel_pkg.sv
//====================
// pixel path widths and word types
// shared by the gamma table, the packer and the top level
//====================
`default_nettype none

package pixel_pkg;

    localparam int PXD_WIDTH   = 12;  // sensor pixel
    localparam int GAMMA_WIDTH = 8;   // table entry and index
    localparam int GAMMA_DEPTH = 256; // one entry per index value
    localparam int DOUT_WIDTH  = 16;  // output word to memory

    typedef logic [PXD_WIDTH-1:0]   pxd_t;
    typedef logic [GAMMA_WIDTH-1:0] gamma_t;
    typedef logic [DOUT_WIDTH-1:0]  dout_t;

endpackage

`default_nettype wire

// File: design/gamma_cfg_if.sv
//====================
// gamma settings and table write port
// decoder side drives, table side samples on mclk
//====================
`timescale 1ns/10ps
`default_nettype none

interface gamma_cfg_if import pixel_pkg::*; ();

    logic   gamma_en; // level, lookup on
    logic   tbl_we;   // one-cycle pulse per data word
    gamma_t tbl_addr; // entry being written
    gamma_t tbl_data; // value for that entry

    modport decoder (
        output gamma_en,
        output tbl_we,
        output tbl_addr,
        output tbl_data
    );

    modport tbl (
        input gamma_en,
        input tbl_we,
        input tbl_addr,
        input tbl_data
    );

endinterface

`default_nettype wire

// File: design/gamma_out_if.sv
//====================
// looked-up pixel stream, one stage after the sensor input
// all fields are registered together in the table stage
//====================
`timescale 1ns/10ps
`default_nettype none

interface gamma_out_if import pixel_pkg::*; ();

    pxd_t   pxd_raw; // untouched pixel for 16 bpp
    gamma_t gval;    // table output or upper bits
    logic   hact;    // line active
    logic   sof;     // start of frame pulse
    logic   eof;     // end of frame pulse

    modport tbl (
        output pxd_raw,
        output gval,
        output hact,
        output sof,
        output eof
    );

    modport packer (
        input pxd_raw,
        input gval,
        input hact,
        input sof,
        input eof
    );

endinterface

`default_nettype wire

// File: design/cmd_decode.sv
//====================
// byte-serial command receiver for the channel registers
// strobe marks AL, then AH and D0..D3 follow on consecutive cycles
// owns the mode bit, gamma enable and the table write pointer
//====================
`timescale 1ns/10ps
`default_nettype none

module cmd_decode import sensor_regs_pkg::*, pixel_pkg::*; #(
    parameter cmd_addr_t SENSOR_BASE_ADDR = 16'h300 // channel register base
) (
    input  wire        mclk,
    input  wire        rst,
    input  wire  [7:0] cmd_ad_i,  // address/data byte
    input  wire        cmd_stb_i, // with first byte
    output logic       bit16_o,   // 16 bpp bypass
    gamma_cfg_if.decoder cfg
);

    localparam cmd_addr_t CTRL_ADDR       = SENSOR_BASE_ADDR + cmd_addr_t'(SENSOR_CTRL_RADDR);
    localparam cmd_addr_t GAMMA_CTRL_ADDR = SENSOR_BASE_ADDR + cmd_addr_t'(SENS_GAMMA_CTRL_RADDR);
    localparam cmd_addr_t GAMMA_AD_ADDR   =
        SENSOR_BASE_ADDR + cmd_addr_t'(SENS_GAMMA_ADDR_DATA_RADDR);
    localparam int SR_WIDTH = (CMD_NUM_BYTES - 1) * 8; // all bytes but the last

    logic  [7:0]         cmd_ad_r;   // input byte, registered
    logic                cmd_stb_r;
    logic                collecting; // inside a command
    logic  [2:0]         byte_cnt;   // index of byte in cmd_ad_r
    logic  [SR_WIDTH-1:0] cmd_sr;    // {D2..., AH, AL} shifting down
    logic                cmd_last;   // sixth byte present this cycle
    cmd_addr_t           cmd_addr;
    cmd_data_t           cmd_data;
    gamma_word_t         gw;
    logic                gamma_wr;   // data-view word for the table

    logic                bit16_r;
    logic                gamma_en_r;
    gamma_t              tbl_addr_r; // write pointer
    logic                tbl_we_r;
    gamma_t              tbl_data_r;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) cmd_stb_r <= 1'b0;
        else     cmd_stb_r <= cmd_stb_i;
    end

    always_ff @(posedge mclk) begin
        cmd_ad_r <= cmd_ad_i;
    end

    // byte counter, a fresh strobe restarts it
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            collecting <= 1'b0;
            byte_cnt   <= 3'd0;
        end else if (cmd_stb_r) begin
            collecting <= 1'b1;
            byte_cnt   <= 3'd1; // AL already in
        end else if (collecting) begin
            byte_cnt <= byte_cnt + 3'd1;
            if (cmd_last) collecting <= 1'b0; // done after D3
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_stb_r || collecting) cmd_sr <= {cmd_ad_r, cmd_sr[SR_WIDTH-1:8]};
    end

    assign cmd_last = collecting && (byte_cnt == 3'(CMD_NUM_BYTES - 1));
    assign cmd_addr = cmd_sr[15:0];                   // {AH, AL}
    assign cmd_data = {cmd_ad_r, cmd_sr[SR_WIDTH-1:16]}; // {D3, D2, D1, D0}
    assign gw       = cmd_data;
    assign gamma_wr = cmd_last && (cmd_addr == GAMMA_AD_ADDR) && !gw.addr.addr_flag;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            bit16_r    <= 1'b0;
            gamma_en_r <= 1'b0;
            tbl_addr_r <= '0;
            tbl_we_r   <= 1'b0;
        end else begin
            tbl_we_r <= gamma_wr; // single pulse
            if (tbl_we_r) tbl_addr_r <= tbl_addr_r + 1'b1; // step after the write
            if (cmd_last) begin
                if (cmd_addr == CTRL_ADDR)       bit16_r    <= cmd_data[SENSOR_16BIT_BIT];
                if (cmd_addr == GAMMA_CTRL_ADDR) gamma_en_r <= cmd_data[SENS_GAMMA_MODE_EN];
                if ((cmd_addr == GAMMA_AD_ADDR) && gw.addr.addr_flag) begin
                    tbl_addr_r <= gw.addr.tbl_addr; // pointer load
                end
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (gamma_wr) tbl_data_r <= gw.data.value;
    end

    assign bit16_o      = bit16_r;
    assign cfg.gamma_en = gamma_en_r;
    assign cfg.tbl_we   = tbl_we_r;
    assign cfg.tbl_addr = tbl_addr_r; // still the old pointer while we is high
    assign cfg.tbl_data = tbl_data_r;

endmodule

`default_nettype wire

// File: design/gamma_lut.sv
//====================
// 256 x 8 gamma table with one registered lookup stage
// indexed by the upper pixel bits, bypassed when gamma is off
// framing and raw pixel travel alongside with the same delay
//====================
`timescale 1ns/10ps
`default_nettype none

module gamma_lut import pixel_pkg::*; (
    input  wire  mclk,
    input  wire  rst,
    input  pxd_t pxd_i,  // sensor pixel
    input  wire  hact_i, // line active
    input  wire  sof_i,  // frame start pulse
    input  wire  eof_i,  // frame end pulse
    gamma_cfg_if.tbl  cfg,
    gamma_out_if.tbl  gout
);

    gamma_t tbl_mem [GAMMA_DEPTH]; // table contents, not cleared
    gamma_t idx;                   // upper pixel bits

    assign idx = pxd_i[PXD_WIDTH-1 -: GAMMA_WIDTH];

    // write port from the decoder
    always_ff @(posedge mclk) begin
        if (cfg.tbl_we) tbl_mem[cfg.tbl_addr] <= cfg.tbl_data;
    end

    // lookup and pixel, no reset
    always_ff @(posedge mclk) begin
        gout.pxd_raw <= pxd_i;
        if (cfg.gamma_en) gout.gval <= tbl_mem[idx];
        else              gout.gval <= idx; // straight pass of top bits
    end

    // framing
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            gout.hact <= 1'b0;
            gout.sof  <= 1'b0;
            gout.eof  <= 1'b0;
        end else begin
            gout.hact <= hact_i;
            gout.sof  <= sof_i;
            gout.eof  <= eof_i;
        end
    end

endmodule

`default_nettype wire

// File: design/pixel_packer.sv
//====================
// output word former after the gamma stage
// 8 bpp packs two table values per word, earlier one in the high byte
// 16 bpp sends the raw pixel left-aligned, one word per pixel
//====================
`timescale 1ns/10ps
`default_nettype none

module pixel_packer import pixel_pkg::*; (
    input  wire   mclk,
    input  wire   rst,
    input  wire   bit16_i, // 16 bpp bypass
    gamma_out_if.packer gout,
    output dout_t dout_o,
    output logic  dout_valid_o, // one cycle per word, no back-pressure
    output logic  sof_o,
    output logic  eof_o
);

    logic   pair_odd; // first of a pair is held
    gamma_t hold_r;   // held first value
    dout_t  dout_r;
    logic   pair_done;
    logic   valid_w;

    assign pair_done = gout.hact && !bit16_i && pair_odd;
    assign valid_w   = bit16_i ? gout.hact : pair_done;

    // pair toggle only moves on 8 bpp pixels, so an odd tail waits for the next line
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pair_odd     <= 1'b0;
            dout_valid_o <= 1'b0;
            sof_o        <= 1'b0;
            eof_o        <= 1'b0;
        end else begin
            if (gout.hact && !bit16_i) pair_odd <= !pair_odd;
            dout_valid_o <= valid_w;
            sof_o        <= gout.sof; // second stage of frame pulse delay
            eof_o        <= gout.eof;
        end
    end

    always_ff @(posedge mclk) begin
        if (gout.hact && !bit16_i && !pair_odd) hold_r <= gout.gval; // first of pair
        if (bit16_i && gout.hact) begin
            dout_r <= {gout.pxd_raw, {(DOUT_WIDTH - PXD_WIDTH){1'b0}}}; // msb aligned
        end else if (pair_done) begin
            dout_r <= {hold_r, gout.gval};
        end
    end

    assign dout_o = dout_r;

endmodule

`default_nettype wire

// File: design/sensor_channel_top.sv
//====================
// sensor channel pixel path, single mclk domain
// commands set mode and gamma, pixels go table then packer
//====================
`timescale 1ns/10ps
`default_nettype none

module sensor_channel_top import sensor_regs_pkg::*, pixel_pkg::*; #(
    parameter cmd_addr_t SENSOR_BASE_ADDR = 16'h300 // register base for this channel
) (
    input  wire        mclk,
    input  wire        rst,
    input  wire  [7:0] cmd_ad_i,  // AL, AH, D0..D3
    input  wire        cmd_stb_i, // with AL
    input  pxd_t       pxd_i,
    input  wire        hact_i,
    input  wire        sof_i,
    input  wire        eof_i,
    output dout_t      dout_o,       // packed or raw word
    output logic       dout_valid_o,
    output logic       sof_o,
    output logic       eof_o
);

    logic bit16; // decoder to packer, level

    gamma_cfg_if gamma_cfg ();
    gamma_out_if gamma_out ();

    cmd_decode #(
        .SENSOR_BASE_ADDR (SENSOR_BASE_ADDR)
    ) cmd_decode_i (
        .mclk      (mclk),
        .rst       (rst),
        .cmd_ad_i  (cmd_ad_i),
        .cmd_stb_i (cmd_stb_i),
        .bit16_o   (bit16),
        .cfg       (gamma_cfg.decoder)
    );

    gamma_lut gamma_lut_i (
        .mclk   (mclk),
        .rst    (rst),
        .pxd_i  (pxd_i),
        .hact_i (hact_i),
        .sof_i  (sof_i),
        .eof_i  (eof_i),
        .cfg    (gamma_cfg.tbl),
        .gout   (gamma_out.tbl)
    );

    pixel_packer pixel_packer_i (
        .mclk         (mclk),
        .rst          (rst),
        .bit16_i      (bit16),
        .gout         (gamma_out.packer),
        .dout_o       (dout_o),
        .dout_valid_o (dout_valid_o),
        .sof_o        (sof_o),
        .eof_o        (eof_o)
    );

endmodule

`default_nettype wire

// File: dv/sensor_channel_assertions.sv
//====================
// concurrent checks on the channel top, attached by bind
// reset state, frame pulse exclusivity, table write width
//====================
`timescale 1ns/10ps
`default_nettype none

module sensor_channel_assertions (
    input wire mclk,
    input wire rst,
    input wire dout_valid_i, // top output
    input wire sof_i,        // top sof_o
    input wire eof_i,        // top eof_o
    input wire tbl_we_i      // decoder to table
);

    int assert_errs = 0; // failed assertions so far

    valid_low_in_reset: assert property (@(posedge mclk) rst |-> !dout_valid_i)
        else begin
            $error("dout_valid_o high while reset is asserted");
            assert_errs++;
        end

    sof_eof_exclusive: assert property (@(posedge mclk) disable iff (rst) !(sof_i && eof_i))
        else begin
            $error("sof_o and eof_o high in the same cycle");
            assert_errs++;
        end

    tbl_we_single: assert property (@(posedge mclk) disable iff (rst) tbl_we_i |=> !tbl_we_i)
        else begin
            $error("tbl_we held high for more than one cycle");
            assert_errs++;
        end

endmodule

bind sensor_channel_top sensor_channel_assertions u_assertions (
    .mclk         (mclk),
    .rst          (rst),
    .dout_valid_i (dout_valid_o),
    .sof_i        (sof_o),
    .eof_i        (eof_o),
    .tbl_we_i     (gamma_cfg.tbl_we)
);

`default_nettype wire

// File: dv/sensor_checker.sv
//====================
// scoreboard for the sensor channel
// decodes the command port, models registers and table,
// queues expected words and compares dout_o and frame pulses
//====================
`timescale 1ns/10ps
`default_nettype none

module sensor_checker import sensor_regs_pkg::*, pixel_pkg::*; #(
    parameter cmd_addr_t SENSOR_BASE_ADDR = 16'h300
) (
    input  wire        mclk,
    input  wire        rst,
    input  wire  [7:0] cmd_ad_i,
    input  wire        cmd_stb_i,
    input  pxd_t       pxd_i,
    input  wire        hact_i,
    input  wire        sof_i,
    input  wire        eof_i,
    input  dout_t      dout_i,       // DUT dout_o
    input  wire        dout_valid_i,
    input  wire        sof_out_i,    // DUT sof_o
    input  wire        eof_out_i,    // DUT eof_o
    output int         word_errs_o,
    output int         frame_errs_o,
    output int         pending_o,    // words still expected
    output logic       pulses_match_o // sof/eof counts in == out
);

    gamma_t     tbl_m [GAMMA_DEPTH]; // table model
    gamma_t     tbl_ptr_m;
    logic       bit16_m;
    logic       gamma_en_m;
    logic [7:0] cmd_buf [CMD_NUM_BYTES];
    int         cmd_idx;             // 0 when idle
    logic       have_first;          // first of a pair held
    gamma_t     first_byte;
    dout_t      exp_q [$];
    dout_t      exp_w;
    logic [1:0] sof_d, eof_d;        // two-cycle pulse delay
    int         sofs_in, sofs_out, eofs_in, eofs_out;

    function automatic gamma_t map_px(input pxd_t px, input logic en);
        gamma_t idx;
        idx = px[PXD_WIDTH-1 -: GAMMA_WIDTH]; // upper 8 bits
        return en ? tbl_m[idx] : idx;
    endfunction

    // expected output word for a pixel completing a pair, or any pixel in 16 bpp
    function automatic dout_t ref_word(input gamma_t first, input pxd_t px,
                                       input logic mode16, input logic en);
        if (mode16) return {px, 4'h0};
        return {first, map_px(px, en)};
    endfunction

    task automatic apply_cmd();
        cmd_addr_t a;
        cmd_data_t d;
        a = {cmd_buf[1], cmd_buf[0]};
        d = {cmd_buf[5], cmd_buf[4], cmd_buf[3], cmd_buf[2]};
        if (a == cmd_addr_t'(SENSOR_BASE_ADDR + SENSOR_CTRL_RADDR)) bit16_m = d[SENSOR_16BIT_BIT];
        if (a == cmd_addr_t'(SENSOR_BASE_ADDR + SENS_GAMMA_CTRL_RADDR))
            gamma_en_m = d[SENS_GAMMA_MODE_EN];
        if (a == cmd_addr_t'(SENSOR_BASE_ADDR + SENS_GAMMA_ADDR_DATA_RADDR)) begin
            if (d[GAMMA_ADDR_FLAG_BIT]) tbl_ptr_m = d[7:0]; // pointer load
            else begin
                tbl_m[tbl_ptr_m] = d[7:0];
                tbl_ptr_m        = tbl_ptr_m + 1'b1; // auto increment
            end
        end
    endtask

    always @(posedge mclk or posedge rst) begin
        if (rst) begin
            {bit16_m, gamma_en_m, have_first} = 3'b000;
            tbl_ptr_m = '0;
            cmd_idx   = 0;
            {sof_d, eof_d} = 4'b0000;
            {sofs_in, sofs_out, eofs_in, eofs_out} = '0;
            exp_q.delete();
            word_errs_o  = 0;
            frame_errs_o = 0;
        end else begin
            // outputs as registered on the previous edge
            if (dout_valid_i) begin
                if (exp_q.size() == 0) begin
                    word_errs_o++;
                    $display("error %0d ns: unexpected word %h on dout_o", $time, dout_i);
                end else begin
                    exp_w = exp_q.pop_front();
                    if (dout_i !== exp_w) begin
                        word_errs_o++;
                        $display("error %0d ns: dout_o expected %h, got %h",
                                 $time, exp_w, dout_i);
                    end
                end
            end
            if ((sof_out_i !== sof_d[1]) || (eof_out_i !== eof_d[1])) begin
                frame_errs_o++;
                $display("error %0d ns: sof_o/eof_o expected %b%b, got %b%b", $time,
                         sof_d[1], eof_d[1], sof_out_i, eof_out_i);
            end
            sofs_out += sof_out_i;
            eofs_out += eof_out_i;
            sofs_in  += sof_i;
            eofs_in  += eof_i;
            sof_d = {sof_d[0], sof_i};
            eof_d = {eof_d[0], eof_i};
            // a strobe restarts command collection
            if (cmd_stb_i) begin
                cmd_buf[0] = cmd_ad_i;
                cmd_idx    = 1;
            end else if (cmd_idx != 0) begin
                cmd_buf[cmd_idx] = cmd_ad_i;
                cmd_idx++;
                if (cmd_idx == CMD_NUM_BYTES) begin
                    apply_cmd();
                    cmd_idx = 0;
                end
            end
            // pixel stream
            if (hact_i) begin
                if (bit16_m) exp_q.push_back(ref_word('0, pxd_i, 1'b1, gamma_en_m));
                else if (!have_first) begin
                    first_byte = map_px(pxd_i, gamma_en_m); // held across lines
                    have_first = 1'b1;
                end else begin
                    exp_q.push_back(ref_word(first_byte, pxd_i, 1'b0, gamma_en_m));
                    have_first = 1'b0;
                end
            end
        end
        pending_o      = exp_q.size();
        pulses_match_o = (sofs_in == sofs_out) && (eofs_in == eofs_out);
    end

endmodule

`default_nettype wire

// File: dv/tb_sensor_channel.sv
//====================
// testbench top for the sensor channel
// drives commands and pixel frames on the falling edge,
// the checker module watches the ports and keeps the score
//====================
`timescale 1ns/10ps
`default_nettype none

module tb_sensor_channel import sensor_regs_pkg::*, pixel_pkg::*; ();

    localparam cmd_addr_t BASE      = 16'h300;
    localparam cmd_addr_t CTRL_A    = BASE + cmd_addr_t'(SENSOR_CTRL_RADDR);
    localparam cmd_addr_t GCTRL_A   = BASE + cmd_addr_t'(SENS_GAMMA_CTRL_RADDR);
    localparam cmd_addr_t GAD_A     = BASE + cmd_addr_t'(SENS_GAMMA_ADDR_DATA_RADDR);
    localparam int        DRAIN_MAX = 500; // cycles allowed to empty the queue

    logic       mclk = 1'b0;
    logic       rst, cmd_stb, hact, sof, eof;
    logic [7:0] cmd_ad;
    pxd_t       pxd;
    dout_t      dout;
    logic       dout_valid, sof_out, eof_out, pulses_match;
    int         word_errs, frame_errs, pending, other_errs, wait_cnt;
    integer     seed;

    always #10 mclk = ~mclk; // 20 ns period

    sensor_channel_top #(.SENSOR_BASE_ADDR(BASE)) dut (
        .mclk (mclk), .rst (rst), .cmd_ad_i (cmd_ad), .cmd_stb_i (cmd_stb),
        .pxd_i (pxd), .hact_i (hact), .sof_i (sof), .eof_i (eof),
        .dout_o (dout), .dout_valid_o (dout_valid), .sof_o (sof_out), .eof_o (eof_out)
    );

    sensor_checker #(.SENSOR_BASE_ADDR(BASE)) checker_i (
        .mclk (mclk), .rst (rst), .cmd_ad_i (cmd_ad), .cmd_stb_i (cmd_stb),
        .pxd_i (pxd), .hact_i (hact), .sof_i (sof), .eof_i (eof),
        .dout_i (dout), .dout_valid_i (dout_valid), .sof_out_i (sof_out), .eof_out_i (eof_out),
        .word_errs_o (word_errs), .frame_errs_o (frame_errs), .pending_o (pending),
        .pulses_match_o (pulses_match)
    );

    task automatic idle(input int n);
        repeat (n) @(negedge mclk);
    endtask

    // AL with strobe, then AH and D0..D3, then the settle gap
    task automatic send_cmd(input cmd_addr_t addr, input cmd_data_t data);
        logic [47:0] bytes;
        bytes = {data, addr};
        for (int i = 0; i < CMD_NUM_BYTES; i++) begin
            @(negedge mclk);
            cmd_stb = (i == 0);
            cmd_ad  = bytes[8*i +: 8];
        end
        @(negedge mclk);
        cmd_stb = 1'b0;
        cmd_ad  = 8'h00;
        idle(10);
    endtask

    // one-cycle sof or eof pulse with a short gap after
    task automatic frame_pulse(input logic is_eof);
        @(negedge mclk);
        if (is_eof) eof = 1'b1;
        else        sof = 1'b1;
        @(negedge mclk);
        sof = 1'b0;
        eof = 1'b0;
        idle(3);
    endtask

    task automatic send_line(input int n, input pxd_t mask);
        for (int i = 0; i < n; i++) begin
            @(negedge mclk);
            hact = 1'b1;
            pxd  = pxd_t'($random(seed)) & mask;
        end
        @(negedge mclk);
        hact = 1'b0;
        idle(3);
    endtask

    task automatic send_frame(input int lines, input int n, input pxd_t mask);
        frame_pulse(1'b0);
        repeat (lines) send_line(n, mask);
        frame_pulse(1'b1);
    endtask

    initial begin
        seed = 32'h1cd6;
        {rst, cmd_stb, hact, sof, eof} = 5'b10000;
        cmd_ad     = 8'h00;
        pxd        = '0;
        other_errs = 0;
        repeat (5) @(posedge mclk);
        @(negedge mclk);
        rst = 1'b0;
        idle(5);
        send_frame(2, 8, 12'hfff); // 8 bpp pass-through after reset
        // pointer to entry f0, the full run wraps back to it
        send_cmd(GAD_A, (cmd_data_t'(1) << GAMMA_ADDR_FLAG_BIT) | 32'h0000_00f0);
        for (int i = 0; i < GAMMA_DEPTH; i++) send_cmd(GAD_A, cmd_data_t'((i * 37 + 11) % 256));
        send_cmd(GCTRL_A, cmd_data_t'(1) << SENS_GAMMA_MODE_EN);
        send_frame(3, 16, 12'hfff);
        // no reload, run goes f0..ff and on into entries 0..f
        for (int i = 0; i < 32; i++) send_cmd(GAD_A, 32'hff00_0000 | ((i * 91 + 200) % 256));
        send_frame(2, 16, 12'h0ff); // indices 0..15 only
        send_cmd(CTRL_A, cmd_data_t'(1) << SENSOR_16BIT_BIT);
        send_frame(1, 6, 12'hfff);
        send_cmd(GCTRL_A, 32'h0);
        send_frame(1, 6, 12'hfff);
        send_cmd(CTRL_A, 32'h0);
        send_cmd(GCTRL_A, cmd_data_t'(1) << SENS_GAMMA_MODE_EN);
        send_cmd(BASE + 16'h1, 32'hffff_ffff);   // unused offsets and a foreign base
        send_cmd(BASE + 16'h6, 32'h0010_0000);
        send_cmd(BASE + 16'h105, 32'h0000_0108);
        send_frame(1, 8, 12'hfff);
        frame_pulse(1'b0);            // odd line carries into the next
        send_line(5, 12'hfff);
        send_line(3, 12'hfff);
        frame_pulse(1'b1);
        wait_cnt = 0;
        while ((pending != 0) && (wait_cnt < DRAIN_MAX)) begin
            @(negedge mclk);
            wait_cnt++;
        end
        if (pending != 0) begin
            other_errs++;
            $display("timeout: %0d expected output words never came on dout_o", pending);
        end
        if (!pulses_match) begin
            other_errs++;
            $display("sof_o or eof_o pulse count differs from the input frame pulses");
        end
        $display("errors: word %0d, framing %0d, assertion %0d, other %0d",
                 word_errs, frame_errs, dut.u_assertions.assert_errs, other_errs);
        if ((word_errs + frame_errs + dut.u_assertions.assert_errs + other_errs) == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/sensor_regs_pkg.sv
design/pixel_pkg.sv
design/gamma_cfg_if.sv
design/gamma_out_if.sv
design/cmd_decode.sv
design/gamma_lut.sv
design/pixel_packer.sv
design/sensor_channel_top.sv
dv/sensor_channel_assertions.sv
dv/sensor_checker.sv
dv/tb_sensor_channel.sv
